// ==== all.f ====
hdl/iir_pkg.sv
hdl/dsp_pkg.sv
hdl/iir_sequencer.sv
hdl/step_counter.sv
hdl/sample_store.sv
hdl/mac_slice.sv
hdl/iir_filter_top.sv
sim/tb_iir_filter.sv

// ==== hdl/dsp_pkg.sv ====
`default_nettype none

package dsp_pkg;

    // --------------------
    // Slice opmode codes
    // --------------------

    // Low two bits select X, next two select Z, as on the DSP48A1
    // X = multiplier, Z = zero or P feedback
    typedef enum logic [7:0] {
        DSP_NOP      = 8'h00,
        DSP_MUL_ZERO = 8'h01,
        DSP_MUL_ACC  = 8'h09
    } dsp_opmode_t;

    // --------------------
    // Slice ports
    // --------------------

    // Operands into the slice, 44 bits
    typedef struct packed {
        dsp_opmode_t        opmode;
        logic signed [17:0] a;
        logic signed [17:0] b;
    } dsp_in_t;

    // Product and accumulator out of the slice, 84 bits
    typedef struct packed {
        logic signed [35:0] m;
        logic signed [47:0] p;
    } dsp_out_t;

endpackage

`default_nettype wire

// ==== hdl/iir_filter_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module iir_filter_top #(
    parameter int FRAC_W = 16
) (
    input  logic                reset,
    input  logic                clk,
    input  iir_pkg::iir_coefs_t coefs,
    input  iir_pkg::sample_t    sample_in,
    input  logic                sample_in_rdy,
    output iir_pkg::sample_t    sample_out,
    output logic                sample_out_rdy
);

    import iir_pkg::*;
    import dsp_pkg::*;

    iir_task_t  tasks;
    logic       repeat_busy;
    logic [2:0] idx;
    sample_t    xy_sel;
    sample_t    sample_hold;
    sample_t    y_new;
    dsp_in_t    dsp_in;
    dsp_out_t   dsp_out;

    // Same accumulator slice the sequencer outputs
    assign y_new = dsp_out.p[FRAC_W +: $bits(sample_t)];

    iir_sequencer #(
        .FRAC_W (FRAC_W)
    ) seq_i (
        .reset          (reset),
        .clk            (clk),
        .coefs          (coefs),
        .sample_in_rdy  (sample_in_rdy),
        .repeat_busy    (repeat_busy),
        .idx            (idx),
        .xy_sel         (xy_sel),
        .sample_hold    (sample_hold),
        .dsp_out        (dsp_out),
        .tasks          (tasks),
        .dsp_in         (dsp_in),
        .sample_out     (sample_out),
        .sample_out_rdy (sample_out_rdy)
    );

    step_counter step_i (
        .reset       (reset),
        .clk         (clk),
        .tasks       (tasks),
        .repeat_busy (repeat_busy),
        .idx         (idx)
    );

    sample_store store_i (
        .reset         (reset),
        .clk           (clk),
        .sample_in     (sample_in),
        .sample_in_rdy (sample_in_rdy),
        .tasks         (tasks),
        .idx           (idx),
        .y_new         (y_new),
        .sample_hold   (sample_hold),
        .xy_sel        (xy_sel)
    );

    mac_slice mac_i (
        .reset   (reset),
        .clk     (clk),
        .dsp_in  (dsp_in),
        .dsp_out (dsp_out)
    );

endmodule

`default_nettype wire

// ==== hdl/iir_pkg.sv ====
`default_nettype none

package iir_pkg;

    // --------------------
    // Data formats
    // --------------------

    // Samples and coefficients share one 18-bit signed word
    typedef logic signed [17:0] sample_t;

    // Products per output sample
    localparam int NUM_TAPS = 5;

    // c0..c2 weight the x taps, c3..c4 the y taps
    typedef struct packed {
        sample_t c0;
        sample_t c1;
        sample_t c2;
        sample_t c3;
        sample_t c4;
    } iir_coefs_t;

    // --------------------
    // Microcode step flags
    // --------------------

    typedef struct packed {
        logic wait_in;
        logic push_x;
        logic push_y;
        logic mul_first;    // product with accumulator cleared
        logic mul_acc;      // product added to P
        logic idx_clear;
        logic idx_inc;
        logic repeat3;
        logic move_result;
        logic jump_zero;
    } iir_task_t;

endpackage

`default_nettype wire

// ==== hdl/iir_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module iir_sequencer #(
    parameter int FRAC_W = 16
) (
    input  logic                reset,
    input  logic                clk,
    input  iir_pkg::iir_coefs_t coefs,
    input  logic                sample_in_rdy,
    input  logic                repeat_busy,
    input  logic [2:0]          idx,
    input  iir_pkg::sample_t    xy_sel,
    input  iir_pkg::sample_t    sample_hold,
    input  dsp_pkg::dsp_out_t   dsp_out,
    output iir_pkg::iir_task_t  tasks,
    output dsp_pkg::dsp_in_t    dsp_in,
    output iir_pkg::sample_t    sample_out,
    output logic                sample_out_rdy
);

    import iir_pkg::*;
    import dsp_pkg::*;

    logic [2:0] pc;
    sample_t    coef_sel;
    sample_t    acc_slice;

    // --------------------
    // Microcode
    // --------------------

    always_comb begin
        tasks = '0;
        case (pc)
            3'd0: tasks.wait_in = 1'b1;
            3'd1: begin
                tasks.push_x    = 1'b1;
                tasks.mul_first = 1'b1;
                tasks.idx_inc   = 1'b1;
            end
            3'd2: begin
                tasks.repeat3 = 1'b1;
                tasks.mul_acc = 1'b1;
                tasks.idx_inc = 1'b1;
            end
            3'd3: begin
                tasks.mul_acc   = 1'b1;
                tasks.idx_clear = 1'b1;
            end
            // Wait for the last product to reach P
            3'd4: tasks.repeat3 = 1'b1;
            3'd5: begin
                tasks.move_result = 1'b1;
                tasks.push_y      = 1'b1;
                tasks.jump_zero   = 1'b1;
            end
            default: tasks.jump_zero = 1'b1;
        endcase
    end

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            pc <= 3'd0;
        end else if (tasks.jump_zero) begin
            pc <= 3'd0;
        end else if ((tasks.wait_in && !sample_in_rdy) || (tasks.repeat3 && repeat_busy)) begin
            pc <= pc;
        end else begin
            pc <= pc + 3'd1;
        end
    end

    // --------------------
    // Operand issue
    // --------------------

    always_comb begin
        case (idx)
            3'd0:    coef_sel = coefs.c0;
            3'd1:    coef_sel = coefs.c1;
            3'd2:    coef_sel = coefs.c2;
            3'd3:    coef_sel = coefs.c3;
            3'd4:    coef_sel = coefs.c4;
            default: coef_sel = '0;
        endcase
    end

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            dsp_in <= '{opmode: DSP_NOP, a: '0, b: '0};
        end else if (tasks.mul_first) begin
            // First tap takes the fresh input directly
            dsp_in <= '{opmode: DSP_MUL_ZERO, a: coef_sel, b: sample_hold};
        end else if (tasks.mul_acc) begin
            dsp_in <= '{opmode: DSP_MUL_ACC, a: coef_sel, b: xy_sel};
        end else begin
            dsp_in <= '{opmode: DSP_NOP, a: '0, b: '0};
        end
    end

    // --------------------
    // Result
    // --------------------

    // Truncated and wrapping slice of the accumulator
    assign acc_slice = dsp_out.p[FRAC_W +: $bits(sample_t)];

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            sample_out_rdy <= 1'b0;
            sample_out     <= '0;
        end else if (tasks.move_result) begin
            sample_out_rdy <= 1'b1;
            sample_out     <= acc_slice;
        end else begin
            sample_out_rdy <= 1'b0;
            sample_out     <= '0;
        end
    end

    // Slice pipeline must be drained when the result is taken
    assert property (@(posedge reset) disable iff (clk)
        tasks.move_result |-> (dsp_in.opmode == DSP_NOP)
                            && ($past(dsp_in.opmode, 1) == DSP_NOP)
                            && ($past(dsp_in.opmode, 2) == DSP_NOP))
        else $error("move_result while a multiply is still in the slice");

endmodule

`default_nettype wire

// ==== hdl/mac_slice.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_slice (
    input  logic              reset,
    input  logic              clk,
    input  dsp_pkg::dsp_in_t  dsp_in,
    output dsp_pkg::dsp_out_t dsp_out
);

    import dsp_pkg::*;

    logic signed [17:0] a_r;
    logic signed [17:0] b_r;
    logic signed [35:0] m_r;
    logic signed [47:0] p_r;
    logic signed [47:0] m_ext;
    dsp_opmode_t        op1;
    dsp_opmode_t        op2;

    // --------------------
    // Operand and M stages
    // --------------------

    always_ff @(posedge reset) begin
        a_r <= dsp_in.a;
        b_r <= dsp_in.b;
        m_r <= a_r * b_r;
    end

    // Opmode follows the data so it lines up with M
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            op1 <= DSP_NOP;
            op2 <= DSP_NOP;
        end else begin
            op1 <= dsp_in.opmode;
            op2 <= op1;
        end
    end

    // --------------------
    // P stage
    // --------------------

    assign m_ext = {{12{m_r[35]}}, m_r};

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            p_r <= '0;
        end else begin
            case (op2)
                DSP_MUL_ZERO: p_r <= m_ext;
                DSP_MUL_ACC:  p_r <= p_r + m_ext;
                default:      p_r <= p_r;
            endcase
        end
    end

    assign dsp_out = '{m: m_r, p: p_r};

    assert property (@(posedge reset) disable iff (clk)
        !$isunknown(dsp_in.opmode)
        && (dsp_in.opmode inside {DSP_NOP, DSP_MUL_ZERO, DSP_MUL_ACC}))
        else $error("unknown opmode 0x%02h", dsp_in.opmode);

endmodule

`default_nettype wire

// ==== hdl/sample_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module sample_store (
    input  logic               reset,
    input  logic               clk,
    input  iir_pkg::sample_t   sample_in,
    input  logic               sample_in_rdy,
    input  iir_pkg::iir_task_t tasks,
    input  logic [2:0]         idx,
    input  iir_pkg::sample_t   y_new,
    output iir_pkg::sample_t   sample_hold,
    output iir_pkg::sample_t   xy_sel
);

    import iir_pkg::*;

    // x[n], x[n-1], x[n-2], y[n-1], y[n-2]
    sample_t xy_line [NUM_TAPS];

    // Input capture on every strobe
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            sample_hold <= '0;
        end else if (sample_in_rdy) begin
            sample_hold <= sample_in;
        end
    end

    // --------------------
    // Delay line
    // --------------------

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            for (int i = 0; i < NUM_TAPS; i++) begin
                xy_line[i] <= '0;
            end
        end else begin
            if (tasks.push_x) begin
                xy_line[0] <= sample_hold;
                xy_line[1] <= xy_line[0];
                xy_line[2] <= xy_line[1];
            end
            // New output becomes y[n-1]
            if (tasks.push_y) begin
                xy_line[3] <= y_new;
                xy_line[4] <= xy_line[3];
            end
        end
    end

    // Word for the current tap
    assign xy_sel = (idx < 3'(NUM_TAPS)) ? xy_line[idx] : '0;

endmodule

`default_nettype wire

// ==== hdl/step_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module step_counter (
    input  logic               reset,
    input  logic               clk,
    input  iir_pkg::iir_task_t tasks,
    output logic               repeat_busy,
    output logic [2:0]         idx
);

    import iir_pkg::*;

    logic [1:0] rep_cnt;
    logic [1:0] rep_max;

    // --------------------
    // Repeat counter
    // --------------------

    // Counts 0,1,2 on a repeat3 step, stays at 0 otherwise
    assign rep_max     = tasks.repeat3 ? 2'd2 : 2'd0;
    assign repeat_busy = (rep_cnt != rep_max);

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            rep_cnt <= 2'd0;
        end else if (rep_cnt == rep_max) begin
            rep_cnt <= 2'd0;
        end else begin
            rep_cnt <= rep_cnt + 2'd1;
        end
    end

    // --------------------
    // Tap index
    // --------------------

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            idx <= 3'd0;
        end else if (tasks.idx_clear) begin
            idx <= 3'd0;
        end else if (tasks.idx_inc) begin
            idx <= idx + 3'd1;
        end
    end

    // Program must clear the index before it runs past the last tap
    assert property (@(posedge reset) disable iff (clk) idx <= 3'(NUM_TAPS - 1))
        else $error("idx out of range: %0d", idx);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build the IIR filter testbench with Verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_iir_filter -f all.f -o sim_iir \
    > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_iir > sim.log 2>&1
cat sim.log

grep -q "ALL TESTS PASSED" sim.log && echo "simulation result: pass" \
    || { echo "simulation result: fail"; exit 1; }

// ==== sim/tb_iir_filter.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_iir_filter;

    import iir_pkg::*;

    localparam int FRAC_W           = 16;
    localparam int CLK_PERIOD       = 100;
    localparam int NUM_TESTS        = 6;
    localparam int SAMPLES_PER_TEST = 20;
    localparam int STROBE_SPACING   = 12;
    localparam int WATCHDOG_CYCLES  = NUM_TESTS * SAMPLES_PER_TEST * STROBE_SPACING + 200;

    // The DUT clocks on reset and resets on clk
    logic       reset;
    logic       clk;
    iir_coefs_t coefs;
    sample_t    sample_in;
    logic       sample_in_rdy;
    sample_t    sample_out;
    logic       sample_out_rdy;

    logic [31:0] lfsr_state      = 32'h45ad;
    sample_t     expected_y      = '0;
    logic        strobe_sent     = 1'b0;
    logic        started         = 1'b0;
    int          error_count     = 0;
    int          tests_run       = 0;
    int          tests_failed    = 0;
    int          samples_checked = 0;

    // Reference history
    sample_t hist_x1 = '0;
    sample_t hist_x2 = '0;
    sample_t hist_y1 = '0;
    sample_t hist_y2 = '0;

    iir_filter_top #(
        .FRAC_W (FRAC_W)
    ) dut_i (
        .reset          (reset),
        .clk            (clk),
        .coefs          (coefs),
        .sample_in      (sample_in),
        .sample_in_rdy  (sample_in_rdy),
        .sample_out     (sample_out),
        .sample_out_rdy (sample_out_rdy)
    );

    initial begin
        reset = 1'b0;
        forever #(CLK_PERIOD / 2) reset = ~reset;
    end

    always @(posedge reset) begin
        started <= 1'b1;
    end

    // --------------------
    // Random numbers
    // --------------------

    function automatic logic lfsr_bit();
        logic lsb;
        lsb = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (lsb) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return lsb;
    endfunction

    function automatic logic [31:0] random_bits(input int width);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < width; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    // Sign-extended random value of the given width
    function automatic sample_t random_signed(input int width);
        logic [31:0] v;
        v = random_bits(width);
        return sample_t'($signed(v << (32 - width)) >>> (32 - width));
    endfunction

    // --------------------
    // Reference model
    // --------------------

    task automatic model_step(input iir_coefs_t c, input sample_t x, output sample_t y);
        logic signed [47:0] acc;
        acc = 48'($signed(c.c0)) * 48'(x)
            + 48'($signed(c.c1)) * 48'(hist_x1)
            + 48'($signed(c.c2)) * 48'(hist_x2)
            + 48'($signed(c.c3)) * 48'(hist_y1)
            + 48'($signed(c.c4)) * 48'(hist_y2);
        // Truncate below FRAC_W, wrap above
        y = acc[FRAC_W +: 18];
        hist_x2 = hist_x1;
        hist_x1 = x;
        hist_y2 = hist_y1;
        hist_y1 = y;
    endtask

    // --------------------
    // Stimulus
    // --------------------

    task automatic send_sample(input iir_coefs_t c, input sample_t x);
        sample_t y;
        logic    seen;
        model_step(c, x, y);
        seen = 1'b0;
        @(posedge reset);
        coefs         <= c;
        sample_in     <= x;
        sample_in_rdy <= 1'b1;
        expected_y    <= y;
        strobe_sent   <= 1'b1;
        @(posedge reset);
        sample_in_rdy <= 1'b0;
        repeat (STROBE_SPACING - 1) begin
            @(negedge reset);
            if (sample_out_rdy) begin
                seen = 1'b1;
            end
        end
        if (seen) begin
            samples_checked++;
        end else begin
            error_count++;
            $display("no sample_out_rdy pulse followed the strobe for sample 0x%05h", x);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before) begin
            $display("test %-14s ok", name);
        end else begin
            tests_failed++;
            $display("test %-14s failed, %0d errors", name, error_count - errors_before);
        end
    endtask

    // --------------------
    // Checks
    // --------------------

    // Quiet output between reset and the first strobe
    assert property (@(posedge reset) (started && !strobe_sent) |-> !sample_out_rdy)
        else begin
            error_count++;
            $display("FAIL sample_out_rdy: got 0x%0h expected 0x0 before any strobe",
                     $sampled(sample_out_rdy));
        end

    assert property (@(posedge reset) (started && !strobe_sent) |-> (sample_out == '0))
        else begin
            error_count++;
            $display("FAIL sample_out: got 0x%05h expected 0x00000 before any strobe",
                     $sampled(sample_out));
        end

    assert property (@(posedge reset) sample_out_rdy |-> (sample_out == expected_y))
        else begin
            error_count++;
            $display("FAIL sample_out: got 0x%05h expected 0x%05h",
                     $sampled(sample_out), $sampled(expected_y));
        end

    // Pulse lands 10 cycles after its strobe, and never without one
    assert property (@(posedge reset) disable iff (clk)
        $past(sample_in_rdy, 10) |-> sample_out_rdy)
        else begin
            error_count++;
            $display("FAIL sample_out_rdy: got 0x0 expected 0x1 ten cycles after a strobe");
        end

    assert property (@(posedge reset) disable iff (clk)
        sample_out_rdy |-> $past(sample_in_rdy, 10))
        else begin
            error_count++;
            $display("FAIL sample_out_rdy: got 0x1 expected 0x0 with no strobe before it");
        end

    assert property (@(posedge reset) disable iff (clk)
        sample_out_rdy |-> !$past(sample_out_rdy))
        else begin
            error_count++;
            $display("FAIL sample_out_rdy: got 0x1 expected 0x0 on the second pulse cycle");
        end

    // --------------------
    // Test sequence
    // --------------------

    initial begin
        iir_coefs_t c;
        sample_t    step;
        int         errors_before;
        clk           = 1'b1;
        coefs         = '0;
        sample_in     = '0;
        sample_in_rdy = 1'b0;

        errors_before = error_count;
        repeat (8) @(posedge reset);
        clk <= 1'b0;
        repeat (6) @(posedge reset);
        finish_test("reset_idle", errors_before);

        // Unity gain on x[n] only
        errors_before = error_count;
        c = '0;
        c.c0 = sample_t'(1 << FRAC_W);
        repeat (SAMPLES_PER_TEST) begin
            send_sample(c, random_signed(18));
        end
        finish_test("pass_through", errors_before);

        errors_before = error_count;
        c = '0;
        c.c0 = random_signed(18);
        c.c1 = random_signed(18);
        c.c2 = random_signed(18);
        repeat (SAMPLES_PER_TEST) begin
            send_sample(c, random_signed(18));
        end
        finish_test("fir_only", errors_before);

        // Gain near 1.5 on a full-scale step drives the output past full scale
        errors_before = error_count;
        c.c0 = sample_t'(3 << (FRAC_W - 1));
        c.c1 = random_signed(14);
        c.c2 = random_signed(14);
        c.c3 = random_signed(13);
        c.c4 = random_signed(13);
        step = sample_t'(18'h2_0000);
        repeat (SAMPLES_PER_TEST) begin
            send_sample(c, step);
        end
        finish_test("feedback_step", errors_before);

        errors_before = error_count;
        repeat (5) begin
            send_sample(c, random_signed(18));
        end
        repeat (30) @(posedge reset);
        finish_test("timing_idle", errors_before);

        // New coefficients on every sample, history carries over
        errors_before = error_count;
        repeat (SAMPLES_PER_TEST) begin
            c.c0 = random_signed(17);
            c.c1 = random_signed(17);
            c.c2 = random_signed(17);
            c.c3 = random_signed(14);
            c.c4 = random_signed(14);
            send_sample(c, random_signed(18));
        end
        finish_test("coef_change", errors_before);

        repeat (4) @(posedge reset);
        $display("tests run %0d, tests failed %0d, samples checked %0d, errors %0d",
                 tests_run, tests_failed, samples_checked, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog timeout after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
